//--- all.f
+incdir+hw
hw/spi_pkg.sv
hw/spi_xfer_if.sv
hw/spi_sequencer.sv
hw/spi_shift_engine.sv
hw/quick_spi_top.sv
testbench/tb_quick_spi.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_quick_spi -o tb_quick_spi \
    && ./obj_dir/tb_quick_spi > sim.log 2>&1
grep -qsx "test passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- testbench/tb_quick_spi.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module tb_quick_spi
    import spi_pkg::*;
();

    // Clocks allowed per wait before giving up
    localparam int TIMEOUT_CLKS = 1000;
    localparam int SEL_WR_READY = 0;
    localparam int SEL_RD_VALID = 1;

    logic      clk_i;
    logic      rst_i;
    logic      wrdata_valid_i;
    logic      wrdata_ready_o;
    spi_len_t  wrdata_len_i;
    spi_data_t wrdata_i;
    logic      rddata_valid_o;
    logic      rddata_ready_i;
    spi_data_t rddata_mask_o;
    spi_data_t rddata_o;
    logic      sclk_o;
    logic      cs_n_o;
    logic      sdata_i;
    logic      sdata_o;

    // Run bookkeeping
    int err_cnt;
    int test_cnt;
    int bad_test_cnt;
    bit aborted;

    // Device model state
    spi_data_t dev_pattern;
    spi_data_t cap_bits;
    int        rise_cnt;
    int        fall_cnt;
    int        setup_cnt;
    int        setup_at_fall;
    bit        fall_seen;
    bit        fall_pend;
    logic      sclk_last;
    logic      cs_last;

    quick_spi_top u_quick_spi_top (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wrdata_valid_i (wrdata_valid_i),
        .wrdata_ready_o (wrdata_ready_o),
        .wrdata_len_i   (wrdata_len_i),
        .wrdata_i       (wrdata_i),
        .rddata_valid_o (rddata_valid_o),
        .rddata_ready_i (rddata_ready_i),
        .rddata_mask_o  (rddata_mask_o),
        .rddata_o       (rddata_o),
        .sclk_o         (sclk_o),
        .cs_n_o         (cs_n_o),
        .sdata_i        (sdata_i),
        .sdata_o        (sdata_o)
    );

    // 20 ns system clock
    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Device side monitor, samples the SPI pins between clock edges
    always @(negedge clk_i) begin
        // Chip select just fell, start of a new frame
        if (cs_last && !cs_n_o) begin
            rise_cnt      = 0;
            fall_cnt      = 0;
            setup_cnt     = 0;
            setup_at_fall = 0;
            fall_seen     = 1'b0;
            cap_bits      = '0;
        end
        if (!cs_n_o) begin
            if (sclk_last && !sclk_o) begin
                if (!fall_seen) begin
                    setup_at_fall = setup_cnt;
                    fall_seen     = 1'b1;
                end
                fall_pend = 1'b1;
            end else if (!fall_seen) begin
                setup_cnt++;
            end
            // Device latches sdata_o on rising SCLK
            if (!sclk_last && sclk_o) begin
                if (rise_cnt < `SPI_MAX_LEN) begin
                    cap_bits[rise_cnt] = sdata_o;
                end
                rise_cnt++;
            end
        end
        sclk_last = sclk_o;
        cs_last   = cs_n_o;
    end

    // Next device bit goes out on the clock after a falling SCLK
    always @(posedge clk_i) begin
        if (fall_pend) begin
            if (fall_cnt < `SPI_MAX_LEN) begin
                sdata_i <= dev_pattern[fall_cnt];
            end
            fall_cnt++;
            fall_pend = 1'b0;
        end
    end

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    // Poll a DUT output at falling clock edges until it is high
    task automatic wait_output(input int sel, output bit ok, output int clks);
        ok   = 1'b0;
        clks = 0;
        while (!ok && clks < TIMEOUT_CLKS) begin
            @(negedge clk_i);
            ok = (sel == SEL_WR_READY) ? wrdata_ready_o : rddata_valid_o;
            clks++;
        end
        if (!ok) begin
            $display("Timed out at %0t ns waiting for %s to go high", $time,
                     (sel == SEL_WR_READY) ? "wrdata_ready_o" : "rddata_valid_o");
            err_cnt++;
            aborted = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            bad_test_cnt++;
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // One frame from request to response handshake, bp_cycles of consumer stall
    task automatic do_transfer(input spi_len_t len, input spi_data_t wdata,
                               input spi_data_t pattern, input int bp_cycles);
        bit        ok;
        int        clks;
        spi_data_t exp_rd;
        spi_data_t exp_mask;
        spi_data_t held_rd;
        spi_data_t held_mask;
        if (aborted) begin
            return;
        end
        // Bit k sampled at rising edge k lands at bit len-1-k
        exp_rd   = '0;
        exp_mask = '0;
        for (int k = 0; k < int'(len); k++) begin
            exp_mask[k]                = 1'b1;
            exp_rd[int'(len) - 1 - k]  = pattern[k];
        end
        wait_output(SEL_WR_READY, ok, clks);
        if (!ok) begin
            return;
        end
        @(posedge clk_i);
        dev_pattern = pattern;
        wrdata_valid_i <= 1'b1;
        wrdata_len_i   <= len;
        wrdata_i       <= wdata;
        @(posedge clk_i);
        wrdata_valid_i <= 1'b0;
        @(negedge clk_i);
        if (cs_n_o) begin
            report_fail("cs_n_o not low on the clock after acceptance");
        end
        wait_output(SEL_RD_VALID, ok, clks);
        if (!ok) begin
            return;
        end
        if (!cs_n_o) begin
            report_fail("cs_n_o still low while rddata_valid_o is high");
        end
        if (rise_cnt != int'(len)) begin
            report_fail($sformatf("%0d rising SCLK edges, expected %0d", rise_cnt, len));
        end
        // Device must have seen the write word LSB first
        if (((cap_bits ^ wdata) & exp_mask) != '0) begin
            report_fail($sformatf("sdata_o bits %h, expected %h", cap_bits & exp_mask,
                                  wdata & exp_mask));
        end
        if (len != 0 && setup_at_fall < `SPI_CS_SETUP_CLKS) begin
            report_fail($sformatf("first SCLK fall %0d clocks after cs_n_o", setup_at_fall));
        end
        if ((rddata_o & rddata_mask_o) != exp_rd) begin
            report_fail($sformatf("rddata_o %h, expected %h", rddata_o & rddata_mask_o, exp_rd));
        end
        if (rddata_mask_o != exp_mask) begin
            report_fail($sformatf("rddata_mask_o %h, expected %h", rddata_mask_o, exp_mask));
        end
        held_rd   = rddata_o;
        held_mask = rddata_mask_o;
        // Consumer stalls, response and SPI pins hold still
        for (int c = 0; c < bp_cycles; c++) begin
            @(negedge clk_i);
            if (!rddata_valid_o || rddata_o != held_rd || rddata_mask_o != held_mask) begin
                report_fail("response changed during back-pressure");
            end
            if (wrdata_ready_o) begin
                report_fail("wrdata_ready_o high during back-pressure");
            end
            if (!sclk_o || !cs_n_o) begin
                report_fail("SCLK or chip select active during back-pressure");
            end
        end
        @(posedge clk_i);
        rddata_ready_i <= 1'b1;
        @(posedge clk_i);
        rddata_ready_i <= 1'b0;
        @(negedge clk_i);
        if (rddata_valid_o) begin
            report_fail("rddata_valid_o still high after the response handshake");
        end
        // Quiet time runs from the transfer end, stall cycles included
        wait_output(SEL_WR_READY, ok, clks);
        if (ok && (bp_cycles + 2 + clks) < `SPI_QUIET_CLKS) begin
            report_fail($sformatf("wrdata_ready_o back %0d clocks after transfer end",
                                  bp_cycles + 2 + clks));
        end
    endtask

    task automatic test_reset_state();
        int errs;
        int clks;
        bit ok;
        errs = err_cnt;
        @(negedge clk_i);
        if (!cs_n_o || !sclk_o || rddata_valid_o) begin
            report_fail("cs_n_o, sclk_o or rddata_valid_o wrong after reset");
        end
        wait_output(SEL_WR_READY, ok, clks);
        finish_test("reset_state", errs);
    endtask

    task automatic test_full_write();
        int errs;
        errs = err_cnt;
        do_transfer(spi_len_t'(16), 16'hA5C3, 16'h0F0F, 0);
        finish_test("full_write", errs);
    endtask

    task automatic test_read_mask();
        int errs;
        errs = err_cnt;
        do_transfer(spi_len_t'(11), 16'h1234, 16'hB36D, 0);
        do_transfer(spi_len_t'(5), 16'hFFFF, 16'h0015, 0);
        finish_test("read_mask", errs);
    endtask

    task automatic test_random_lengths();
        int errs;
        errs = err_cnt;
        for (int i = 0; i < 10; i++) begin
            do_transfer(spi_len_t'(1 + ($urandom % 16)), spi_data_t'($urandom),
                        spi_data_t'($urandom), 0);
        end
        finish_test("random_lengths", errs);
    endtask

    task automatic test_back_pressure();
        int errs;
        errs = err_cnt;
        do_transfer(spi_len_t'(9), spi_data_t'($urandom), spi_data_t'($urandom),
                    3 + int'($urandom % 20));
        // Next frame after the stall runs normally
        do_transfer(spi_len_t'(16), spi_data_t'($urandom), spi_data_t'($urandom), 0);
        finish_test("back_pressure", errs);
    endtask

    initial begin
        void'($urandom(85513));
        err_cnt        = 0;
        test_cnt       = 0;
        bad_test_cnt   = 0;
        aborted        = 1'b0;
        fall_pend      = 1'b0;
        fall_cnt       = 0;
        sclk_last      = 1'b1;
        cs_last        = 1'b1;
        dev_pattern    = '0;
        rst_i          = 1'b1;
        wrdata_valid_i = 1'b0;
        wrdata_len_i   = '0;
        wrdata_i       = '0;
        rddata_ready_i = 1'b0;
        sdata_i        = 1'b0;
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        test_reset_state();
        test_full_write();
        test_read_mask();
        test_random_lengths();
        test_back_pressure();
        $display("tests run %0d, failing tests %0d, check errors %0d",
                 test_cnt, bad_test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- hw/quick_spi_top.sv
`timescale 1ns/1ps

module quick_spi_top
    import spi_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    // Request side
    input  logic      wrdata_valid_i,
    output logic      wrdata_ready_o,
    input  spi_len_t  wrdata_len_i,
    input  spi_data_t wrdata_i,
    // Response side
    output logic      rddata_valid_o,
    input  logic      rddata_ready_i,
    output spi_data_t rddata_mask_o,
    output spi_data_t rddata_o,
    // SPI pins
    output logic      sclk_o,
    output logic      cs_n_o,
    input  logic      sdata_i,
    output logic      sdata_o
);

    // Control path between the two stages
    spi_xfer_if xfer ();

    // Handshakes, timing and chip select
    spi_sequencer u_seq (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wrdata_valid_i (wrdata_valid_i),
        .wrdata_ready_o (wrdata_ready_o),
        .wrdata_len_i   (wrdata_len_i),
        .wrdata_i       (wrdata_i),
        .rddata_valid_o (rddata_valid_o),
        .rddata_ready_i (rddata_ready_i),
        .rddata_mask_o  (rddata_mask_o),
        .cs_n_o         (cs_n_o),
        .xfer           (xfer.seq)
    );

    // SCLK generation and data shifting
    spi_shift_engine u_eng (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .xfer     (xfer.eng),
        .sclk_o   (sclk_o),
        .sdata_i  (sdata_i),
        .sdata_o  (sdata_o),
        .rddata_o (rddata_o)
    );

endmodule

//--- hw/spi_shift_engine.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_shift_engine
    import spi_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    // Control from the sequencer
    spi_xfer_if.eng   xfer,
    // SPI pins
    output logic      sclk_o,
    input  logic      sdata_i,
    output logic      sdata_o,
    // Collected read word
    output spi_data_t rddata_o
);

    // Clocks per SCLK half period
    localparam int HALF_DIV = `SPI_CLK_DIV / 2;
    localparam int DIV_W    = $clog2(`SPI_CLK_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(HALF_DIV - 1);

    logic [DIV_W-1:0]          div_cnt;
    logic                      sclk_q;
    logic                      sclk_prev;
    logic                      sclk_rise;
    logic [`SPI_HOLD_CLKS-1:0] hold_q;
    logic                      tx_advance;
    spi_len_t                  bits_left;
    spi_data_t                 tx_q;
    spi_data_t                 rx_q;

    // SCLK divider, parks high with the count cleared when disabled
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sclk_q  <= 1'b1;
            div_cnt <= '0;
        end else if (!xfer.sclk_en) begin
            sclk_q  <= 1'b1;
            div_cnt <= '0;
        end else if (div_cnt == DIV_LAST) begin
            // First toggle after enable is the falling edge
            sclk_q  <= ~sclk_q;
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign xfer.sclk_idle = sclk_q && (div_cnt == '0);
    assign sclk_o         = sclk_q;

    // Previous SCLK level for edge detection
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sclk_prev <= 1'b1;
        end else begin
            sclk_prev <= sclk_q;
        end
    end

    // Rising edge strobe from the registered SCLK level
    assign sclk_rise = sclk_q && !sclk_prev;

    // Remaining bits, reloaded on every frame start
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bits_left <= '0;
        end else if (xfer.load) begin
            bits_left <= xfer.len;
        end else if (sclk_rise) begin
            bits_left <= bits_left - 1'b1;
        end
    end

    assign xfer.bits_done = (bits_left == '0);

    // Delay line for the rising edge strobe, sets the sdata_o hold time
    always_ff @(posedge clk_i) begin
        if (rst_i || xfer.load) begin
            hold_q <= '0;
        end else begin
            hold_q[0] <= sclk_rise;
            for (int i = 1; i < `SPI_HOLD_CLKS; i++) begin
                hold_q[i] <= hold_q[i-1];
            end
        end
    end

    assign tx_advance = hold_q[`SPI_HOLD_CLKS-1];

    // Transmit register, LSB goes out first
    always_ff @(posedge clk_i) begin
        if (xfer.load) begin
            tx_q <= xfer.wdata;
        end else if (tx_advance) begin
            tx_q <= tx_q >> 1;
        end
    end

    assign sdata_o = tx_q[0];

    // Receive register, first sampled bit ends up at bit len-1
    always_ff @(posedge clk_i) begin
        if (xfer.load) begin
            rx_q <= '0;
        end else if (sclk_rise) begin
            rx_q <= {rx_q[`SPI_MAX_LEN-2:0], sdata_i};
        end
    end

    assign rddata_o = rx_q;

    // Bit count stays at zero until the next frame start
    a_done_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
        (xfer.bits_done && !xfer.load) |=> xfer.bits_done)
        else $error("bit count left zero without load");

    // Device sees sdata_o steady through the hold window
    a_sdata_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        sclk_rise |=> $stable(sdata_o) [*`SPI_HOLD_CLKS])
        else $error("sdata_o changed inside the hold window");

endmodule

//--- hw/spi_sequencer.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_sequencer
    import spi_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    // Request side
    input  logic      wrdata_valid_i,
    output logic      wrdata_ready_o,
    input  spi_len_t  wrdata_len_i,
    input  spi_data_t wrdata_i,
    // Response side
    output logic      rddata_valid_o,
    input  logic      rddata_ready_i,
    output spi_data_t rddata_mask_o,
    // Device chip select
    output logic      cs_n_o,
    // Control toward the shift engine
    spi_xfer_if.seq   xfer
);

    // Timer reload values
    localparam logic [`SPI_TIMER_W-1:0] SETUP_CNT = `SPI_CS_SETUP_CLKS;
    localparam logic [`SPI_TIMER_W-1:0] QUIET_CNT = `SPI_QUIET_CLKS;
    localparam spi_data_t ALL_ONES = '1;

    spi_state_e              state_q;
    spi_state_e              state_d;
    logic [`SPI_TIMER_W-1:0] timer_q;
    logic                    timer_done;
    logic                    accept;
    logic                    xfer_end;
    spi_data_t               mask_q;

    // Request handshake, only possible in IDLE
    assign accept = (state_q == IDLE) && wrdata_valid_i;

    // Last rising edge seen while SCLK was running
    assign xfer_end = (state_q == TRANSFER) && xfer.bits_done;

    assign timer_done = (timer_q == '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            RESET: begin
                // Hold off requests until SCLK is parked
                if (xfer.sclk_idle) begin
                    state_d = IDLE;
                end
            end
            IDLE: begin
                if (accept) begin
                    state_d = CS_SETUP;
                end
            end
            CS_SETUP: begin
                if (timer_done) begin
                    state_d = TRANSFER;
                end
            end
            TRANSFER: begin
                if (xfer.bits_done) begin
                    state_d = RESP_VALID;
                end
            end
            RESP_VALID: begin
                if (rddata_ready_i) begin
                    state_d = QUIET;
                end
            end
            QUIET: begin
                if (timer_done) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = RESET;
            end
        endcase
    end

    // Shared down counter for setup and quiet time
    // Quiet count starts at transfer end and keeps running during back-pressure
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            timer_q <= '0;
        end else if (accept) begin
            timer_q <= SETUP_CNT;
        end else if (xfer_end) begin
            timer_q <= QUIET_CNT;
        end else if (!timer_done) begin
            timer_q <= timer_q - 1'b1;
        end
    end

    // Low len bits set, a length of 0 gives an empty mask
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mask_q <= '0;
        end else if (accept) begin
            mask_q <= ~(ALL_ONES << wrdata_len_i);
        end
    end

    // Frame start toward the engine, word and length pass straight through
    assign xfer.load  = accept;
    assign xfer.len   = wrdata_len_i;
    assign xfer.wdata = wrdata_i;

    // SCLK runs from setup expiry until the last bit, never for an empty frame
    assign xfer.sclk_en = !xfer.bits_done &&
                          ((state_q == TRANSFER) || ((state_q == CS_SETUP) && timer_done));

    assign cs_n_o         = !((state_q == CS_SETUP) || (state_q == TRANSFER));
    assign wrdata_ready_o = (state_q == IDLE);
    assign rddata_valid_o = (state_q == RESP_VALID);
    assign rddata_mask_o  = mask_q;

    // Request and response sides are never offered together
    a_ready_valid_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(wrdata_ready_o && rddata_valid_o))
        else $error("wrdata_ready_o and rddata_valid_o both high");

    // Chip select is only driven during setup and transfer
    a_cs_states: assert property (@(posedge clk_i) disable iff (rst_i)
        !cs_n_o |-> (state_q inside {CS_SETUP, TRANSFER}))
        else $error("cs_n_o low outside CS_SETUP or TRANSFER");

    // Engine keeps SCLK parked while a response waits
    a_idle_in_resp: assert property (@(posedge clk_i) disable iff (rst_i)
        rddata_valid_o |-> xfer.sclk_idle)
        else $error("SCLK not idle while rddata_valid_o is high");

endmodule

//--- hw/spi_xfer_if.sv
`timescale 1ns/1ps

interface spi_xfer_if
    import spi_pkg::*;
();

    // One-cycle frame start, only pulsed from IDLE
    logic      load;
    // Bit count, valid with load
    spi_len_t  len;
    // Write word, valid with load
    spi_data_t wdata;
    // Held high while SCLK should toggle
    logic      sclk_en;
    // SCLK parked high with the divider at zero
    logic      sclk_idle;
    // No bits left in the current frame
    logic      bits_done;

    // Sequencer side
    modport seq (
        output load,
        output len,
        output wdata,
        output sclk_en,
        input  sclk_idle,
        input  bits_done
    );

    // Shift engine side
    modport eng (
        input  load,
        input  len,
        input  wdata,
        input  sclk_en,
        output sclk_idle,
        output bits_done
    );

endinterface

//--- hw/spi_pkg.sv
`include "spi_cfg.svh"

package spi_pkg;

    // One data word, write or read
    typedef logic [`SPI_MAX_LEN-1:0] spi_data_t;

    // Bit count of a frame, 0 up to SPI_MAX_LEN
    typedef logic [`SPI_LEN_W-1:0] spi_len_t;

    // Transaction FSM states
    typedef enum logic [2:0] {
        // Wait for SCLK to park after reset
        RESET,
        // Ready for a request
        IDLE,
        // Chip select low, setup timer running
        CS_SETUP,
        // SCLK running until all bits are done
        TRANSFER,
        // Read word offered, waiting for the consumer
        RESP_VALID,
        // Quiet timer finishing before the next frame
        QUIET
    } spi_state_e;

endpackage

//--- hw/spi_cfg.svh
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// Longest frame in bits
`define SPI_MAX_LEN 16

// Length field width, wide enough to hold SPI_MAX_LEN itself
`define SPI_LEN_W 5

// System clocks per SCLK period, kept even so both halves match
`define SPI_CLK_DIV 4

// Clocks from chip select low to SCLK start
`define SPI_CS_SETUP_CLKS 2

// Extra clocks sdata_o holds after a detected rising edge
`define SPI_HOLD_CLKS 1

// Clocks between end of transfer and the next accepted request
`define SPI_QUIET_CLKS 10

// Width of the sequencer down counter
`define SPI_TIMER_W 4

`endif
